// ==== design/dispatch_defines.svh ====
// Dispatch stage parameters
// Widths and counts shared by the dispatch package and all dispatch modules

`ifndef DISPATCH_DEFINES_SVH
`define DISPATCH_DEFINES_SVH

// Uops presented by the uop queue each cycle
`define NUM_DP_UOP        2

// VRF read ports shared by both uops
`define NUM_DP_VRF        4

// ROB size and width of a ROB slot number
`define ROB_DEPTH         8
`define ROB_INDEX_WIDTH   3

// Width of a vector register number
`define VREG_INDEX_WIDTH  5

// Vector register width in bits
`define VLEN              128

// Scalar operand width in bits
`define XLEN              32

`endif

// ==== design/dispatch_pkg.sv ====
// Dispatch package
// Vector types, uop and ROB structs and the execution unit encoding

`include "dispatch_defines.svh"

package dispatch_pkg;

    typedef logic [`VREG_INDEX_WIDTH-1:0] vreg_index_t;
    typedef logic [`VLEN-1:0]             vreg_data_t;
    typedef logic [`ROB_INDEX_WIDTH-1:0]  rob_index_t;
    typedef logic [`XLEN-1:0]             xreg_data_t;
    typedef logic [5:0]                   funct6_t;
    typedef logic [2:0]                   funct3_t;

    // Reservation station picked by a uop
    typedef enum logic {
        ALU = 1'b0,
        MUL = 1'b1
    } exe_unit_e;

    // Uop as delivered by the uop queue
    typedef struct packed {
        vreg_index_t vs1_index;
        logic        vs1_valid;
        vreg_index_t vs2_index;
        logic        vs2_valid;
        vreg_index_t vd_index;
        logic        vd_valid;   // writes vd
        logic        vs3_valid;  // reads vd as a source
        logic        vm;
        exe_unit_e   exe_unit;
        funct6_t     funct6;
        funct3_t     funct3;
        xreg_data_t  rs1_data;
        logic        rs1_valid;
        logic        last_uop;
    } uop_t;

    // One ROB slot as seen by dispatch
    typedef struct packed {
        logic        valid;
        vreg_index_t w_index;
        logic        w_valid;    // result has been written back
        vreg_data_t  w_data;
    } rob_entry_t;

    // Bypass choice per source
    typedef struct packed {
        logic        vs1_use_rob;
        rob_index_t  vs1_rob_index;
        logic        vs2_use_rob;
        rob_index_t  vs2_rob_index;
        logic        vd_use_rob;
        rob_index_t  vd_rob_index;
    } src_sel_t;

    typedef struct packed {
        vreg_data_t  v0;
        vreg_data_t  vs1;
        vreg_data_t  vs2;
        vreg_data_t  vd;
    } operands_t;

    // Payload for the ALU and MUL reservation stations
    typedef struct packed {
        rob_index_t  rob_entry;
        funct6_t     funct6;
        funct3_t     funct3;
        logic        vm;
        vreg_data_t  v0_data;
        vreg_data_t  vs1_data;
        logic        vs1_valid;
        vreg_data_t  vs2_data;
        logic        vs2_valid;
        vreg_data_t  vd_data;
        logic        vd_valid;
        xreg_data_t  rs1_data;
        logic        rs1_valid;
    } rs_uop_t;

    typedef struct packed {
        vreg_index_t w_index;
        logic        last_uop;
    } rob_uop_t;

endpackage

// ==== design/dispatch_rob_hazard.sv ====
// ROB RAW hazard check for one uop
// Finds the youngest ROB writer of each source and decides between a stall,
// a bypass from that ROB slot or a plain VRF read

`include "dispatch_defines.svh"

module dispatch_rob_hazard (
    input  dispatch_pkg::uop_t                        uop,
    input  dispatch_pkg::rob_entry_t [`ROB_DEPTH-1:0] rob_entries,
    input  dispatch_pkg::rob_index_t                  rob_tail,
    output logic                                      hazard,
    output dispatch_pkg::src_sel_t                    src_sel
);

    // Source order is vs1, vs2, vd
    localparam int NUM_SRC = 3;

    dispatch_pkg::vreg_index_t [NUM_SRC-1:0] src_index;
    logic [NUM_SRC-1:0]                      src_valid;
    logic [NUM_SRC-1:0]                      src_hit;
    logic [NUM_SRC-1:0]                      src_ready;
    dispatch_pkg::rob_index_t [NUM_SRC-1:0]  src_slot;

    assign src_index = {uop.vd_index, uop.vs2_index, uop.vs1_index};
    assign src_valid = {uop.vs3_valid, uop.vs2_valid, uop.vs1_valid};

    // Walk from the oldest slot to the youngest, a later match overrides
    always_comb begin
        dispatch_pkg::rob_index_t slot;
        src_hit   = '0;
        src_ready = '0;
        src_slot  = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            for (int d = `ROB_DEPTH-1; d >= 0; d--) begin
                // Distance d from the tail, wraps modulo the ROB depth
                slot = rob_tail - dispatch_pkg::rob_index_t'(d + 1);
                if (src_valid[s] && rob_entries[slot].valid &&
                    rob_entries[slot].w_index == src_index[s]) begin
                    src_hit[s]   = 1'b1;
                    src_ready[s] = rob_entries[slot].w_valid;
                    src_slot[s]  = slot;
                end
            end
        end
    end

    // Writer found but result still pending
    assign hazard = |(src_hit & ~src_ready);

    assign src_sel.vs1_use_rob   = src_hit[0];
    assign src_sel.vs1_rob_index = src_slot[0];
    assign src_sel.vs2_use_rob   = src_hit[1];
    assign src_sel.vs2_rob_index = src_slot[1];
    assign src_sel.vd_use_rob    = src_hit[2];
    assign src_sel.vd_rob_index  = src_slot[2];

endmodule

// ==== design/dispatch_uop_hazard.sv ====
// RAW check between two uops of the same dispatch group
// Flags the younger uop when it reads the destination of the older one

`include "dispatch_defines.svh"

module dispatch_uop_hazard (
    input  dispatch_pkg::uop_t uop_older,
    input  logic               older_valid,
    input  dispatch_pkg::uop_t uop_younger,
    output logic               hazard
);

    logic older_writes;
    logic vs1_match;
    logic vs2_match;
    logic vd_match;

    assign older_writes = older_valid && uop_older.vd_valid;

    // Compare against each source the younger uop actually reads
    assign vs1_match = uop_younger.vs1_valid &&
                       (uop_younger.vs1_index == uop_older.vd_index);
    assign vs2_match = uop_younger.vs2_valid &&
                       (uop_younger.vs2_index == uop_older.vd_index);

    // vd read as vs3 counts as a source too
    assign vd_match  = uop_younger.vs3_valid &&
                       (uop_younger.vd_index == uop_older.vd_index);

    assign hazard = older_writes && (vs1_match || vs2_match || vd_match);

endmodule

// ==== design/dispatch_vrf_read.sv ====
// VRF read port allocation
// Counts the sources of both uops, packs the read indices in program order
// and hands the returned data back to each uop's operands

`include "dispatch_defines.svh"

module dispatch_vrf_read (
    input  dispatch_pkg::uop_t         [`NUM_DP_UOP-1:0] uop,
    output dispatch_pkg::vreg_index_t  [`NUM_DP_VRF-1:0] vrf_rd_index,
    input  dispatch_pkg::vreg_data_t   [`NUM_DP_VRF-1:0] vrf_rd_data,
    input  dispatch_pkg::vreg_data_t                     v0_mask,
    output dispatch_pkg::operands_t    [`NUM_DP_UOP-1:0] vrf_operands,
    output logic                                         struct_hazard
);

    // Per uop sources in port order: vs2, vs1, vd
    localparam int SRC_PER_UOP = 3;
    localparam int NUM_SRC     = `NUM_DP_UOP * SRC_PER_UOP;
    localparam int PORT_W      = $clog2(`NUM_DP_VRF);

    dispatch_pkg::vreg_index_t [NUM_SRC-1:0] src_index;
    logic [NUM_SRC-1:0]                      src_valid;
    logic [NUM_SRC-1:0]                      src_mapped;
    logic [NUM_SRC-1:0][PORT_W-1:0]          src_port;

    for (genvar u = 0; u < `NUM_DP_UOP; u++) begin : gen_src
        assign src_index[u*SRC_PER_UOP]     = uop[u].vs2_index;
        assign src_valid[u*SRC_PER_UOP]     = uop[u].vs2_valid;
        assign src_index[u*SRC_PER_UOP + 1] = uop[u].vs1_index;
        assign src_valid[u*SRC_PER_UOP + 1] = uop[u].vs1_valid;
        assign src_index[u*SRC_PER_UOP + 2] = uop[u].vd_index;
        assign src_valid[u*SRC_PER_UOP + 2] = uop[u].vs3_valid;
    end

    // More sources than ports means uop1 has to wait
    assign struct_hazard = $countones(src_valid) > `NUM_DP_VRF;

    // Fill ports in order and skip invalid sources
    always_comb begin
        int unsigned port;
        port         = 0;
        vrf_rd_index = '0;
        src_mapped   = '0;
        src_port     = '0;
        for (int s = 0; s < NUM_SRC; s++) begin
            if (src_valid[s] && port < `NUM_DP_VRF) begin
                vrf_rd_index[port] = src_index[s];
                src_mapped[s]      = 1'b1;
                src_port[s]        = PORT_W'(port);
                port               = port + 1;
            end
        end
    end

    // Sources left without a port read as zero
    always_comb begin
        for (int u = 0; u < `NUM_DP_UOP; u++) begin
            vrf_operands[u].v0  = v0_mask;
            vrf_operands[u].vs2 = src_mapped[u*SRC_PER_UOP] ?
                                  vrf_rd_data[src_port[u*SRC_PER_UOP]] : '0;
            vrf_operands[u].vs1 = src_mapped[u*SRC_PER_UOP + 1] ?
                                  vrf_rd_data[src_port[u*SRC_PER_UOP + 1]] : '0;
            vrf_operands[u].vd  = src_mapped[u*SRC_PER_UOP + 2] ?
                                  vrf_rd_data[src_port[u*SRC_PER_UOP + 2]] : '0;
        end
    end

endmodule

// ==== design/dispatch_operand_select.sv ====
// Operand select for one uop
// Picks each vector source from the ROB bypass slot or from the VRF

`include "dispatch_defines.svh"

module dispatch_operand_select (
    input  dispatch_pkg::src_sel_t                    src_sel,
    input  dispatch_pkg::rob_entry_t [`ROB_DEPTH-1:0] rob_entries,
    input  dispatch_pkg::operands_t                   vrf_operands,
    output dispatch_pkg::operands_t                   operands
);

    dispatch_pkg::vreg_data_t vs1_rob_data;
    dispatch_pkg::vreg_data_t vs2_rob_data;
    dispatch_pkg::vreg_data_t vd_rob_data;

    // Result data of the youngest writer of each source
    assign vs1_rob_data = rob_entries[src_sel.vs1_rob_index].w_data;
    assign vs2_rob_data = rob_entries[src_sel.vs2_rob_index].w_data;
    assign vd_rob_data  = rob_entries[src_sel.vd_rob_index].w_data;

    // Mask register is never bypassed
    assign operands.v0 = vrf_operands.v0;

    assign operands.vs1 = src_sel.vs1_use_rob ? vs1_rob_data : vrf_operands.vs1;
    assign operands.vs2 = src_sel.vs2_use_rob ? vs2_rob_data : vrf_operands.vs2;
    assign operands.vd  = src_sel.vd_use_rob  ? vd_rob_data  : vrf_operands.vd;

endmodule

// ==== design/dispatch_ctrl.sv ====
// Dispatch issue control
// Decides in program order which uops issue and drives the handshakes
// toward the uop queue, the reservation stations and the ROB

`include "dispatch_defines.svh"

module dispatch_ctrl (
    input  logic                   [`NUM_DP_UOP-1:0] uop_valid,
    input  logic                   [`NUM_DP_UOP-1:0] rob_hazard,
    input  logic                                     uop_hazard,
    input  logic                                     struct_hazard,
    input  dispatch_pkg::exe_unit_e [`NUM_DP_UOP-1:0] exe_unit,
    input  logic                   [`NUM_DP_UOP-1:0] rs_ready_alu,
    input  logic                   [`NUM_DP_UOP-1:0] rs_ready_mul,
    input  logic                   [`NUM_DP_UOP-1:0] rob_push_ready,
    output logic                   [`NUM_DP_UOP-1:0] uop_ready,
    output logic                   [`NUM_DP_UOP-1:0] rs_valid_alu,
    output logic                   [`NUM_DP_UOP-1:0] rs_valid_mul,
    output logic                   [`NUM_DP_UOP-1:0] rob_push_valid
);

    logic [`NUM_DP_UOP-1:0] to_alu;
    logic [`NUM_DP_UOP-1:0] rs_ready;
    logic [`NUM_DP_UOP-1:0] can_issue;
    logic [`NUM_DP_UOP-1:0] issue;

    // Ready of the RS this uop is headed for
    always_comb begin
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            to_alu[i]    = exe_unit[i] == dispatch_pkg::ALU;
            rs_ready[i]  = to_alu[i] ? rs_ready_alu[i] : rs_ready_mul[i];
            can_issue[i] = uop_valid[i] && !rob_hazard[i] &&
                           rs_ready[i] && rob_push_ready[i];
        end
    end

    // Younger uops issue only together with every older one
    always_comb begin
        issue[0] = can_issue[0];
        for (int i = 1; i < `NUM_DP_UOP; i++) begin
            issue[i] = can_issue[i] && issue[i-1] && !uop_hazard && !struct_hazard;
        end
    end

    assign uop_ready      = issue;
    assign rob_push_valid = issue;
    assign rs_valid_alu   = issue & to_alu;
    assign rs_valid_mul   = issue & ~to_alu;

endmodule

// ==== design/vector_dispatch.sv ====
// Vector dispatch stage
// Takes up to two uops per cycle, checks ROB, uop-to-uop and VRF port
// hazards, gathers operands and sends issued uops to the RS and the ROB

`include "dispatch_defines.svh"

module vector_dispatch (
    // Uop queue
    input  logic                       [`NUM_DP_UOP-1:0] uop_valid,
    input  dispatch_pkg::uop_t         [`NUM_DP_UOP-1:0] uop,
    output logic                       [`NUM_DP_UOP-1:0] uop_ready,
    // ALU reservation station
    output logic                       [`NUM_DP_UOP-1:0] rs_valid_alu,
    output dispatch_pkg::rs_uop_t      [`NUM_DP_UOP-1:0] rs_alu,
    input  logic                       [`NUM_DP_UOP-1:0] rs_ready_alu,
    // MUL reservation station
    output logic                       [`NUM_DP_UOP-1:0] rs_valid_mul,
    output dispatch_pkg::rs_uop_t      [`NUM_DP_UOP-1:0] rs_mul,
    input  logic                       [`NUM_DP_UOP-1:0] rs_ready_mul,
    // ROB push, rob_tail is the slot uop0 takes
    output logic                       [`NUM_DP_UOP-1:0] rob_push_valid,
    output dispatch_pkg::rob_uop_t     [`NUM_DP_UOP-1:0] rob_push,
    input  logic                       [`NUM_DP_UOP-1:0] rob_push_ready,
    input  dispatch_pkg::rob_index_t                     rob_tail,
    // VRF read, data returns in the same cycle
    output dispatch_pkg::vreg_index_t  [`NUM_DP_VRF-1:0] vrf_rd_index,
    input  dispatch_pkg::vreg_data_t   [`NUM_DP_VRF-1:0] vrf_rd_data,
    input  dispatch_pkg::vreg_data_t                     v0_mask,
    // All ROB slots for hazard check and bypass
    input  dispatch_pkg::rob_entry_t   [`ROB_DEPTH-1:0]  rob_entries
);

    logic [`NUM_DP_UOP-1:0]                       rob_hazard;
    logic                                         uop_hazard;
    logic                                         struct_hazard;
    dispatch_pkg::src_sel_t    [`NUM_DP_UOP-1:0]  src_sel;
    dispatch_pkg::operands_t   [`NUM_DP_UOP-1:0]  vrf_operands;
    dispatch_pkg::operands_t   [`NUM_DP_UOP-1:0]  operands;
    dispatch_pkg::exe_unit_e   [`NUM_DP_UOP-1:0]  exe_unit;
    dispatch_pkg::rs_uop_t     [`NUM_DP_UOP-1:0]  rs_payload;

    dispatch_vrf_read dispatch_vrf_read_inst (
        .uop           (uop),
        .vrf_rd_index  (vrf_rd_index),
        .vrf_rd_data   (vrf_rd_data),
        .v0_mask       (v0_mask),
        .vrf_operands  (vrf_operands),
        .struct_hazard (struct_hazard)
    );

    // Only uop1 can depend on another uop of the group
    dispatch_uop_hazard dispatch_uop_hazard_inst (
        .uop_older   (uop[0]),
        .older_valid (uop_valid[0]),
        .uop_younger (uop[1]),
        .hazard      (uop_hazard)
    );

    for (genvar i = 0; i < `NUM_DP_UOP; i++) begin : gen_uop
        dispatch_rob_hazard dispatch_rob_hazard_inst (
            .uop         (uop[i]),
            .rob_entries (rob_entries),
            .rob_tail    (rob_tail),
            .hazard      (rob_hazard[i]),
            .src_sel     (src_sel[i])
        );

        dispatch_operand_select dispatch_operand_select_inst (
            .src_sel      (src_sel[i]),
            .rob_entries  (rob_entries),
            .vrf_operands (vrf_operands[i]),
            .operands     (operands[i])
        );

        assign exe_unit[i] = uop[i].exe_unit;

        // Uop i lands in ROB slot rob_tail + i
        assign rs_payload[i].rob_entry = rob_tail + dispatch_pkg::rob_index_t'(i);
        assign rs_payload[i].funct6    = uop[i].funct6;
        assign rs_payload[i].funct3    = uop[i].funct3;
        assign rs_payload[i].vm        = uop[i].vm;
        assign rs_payload[i].v0_data   = operands[i].v0;
        assign rs_payload[i].vs1_data  = operands[i].vs1;
        assign rs_payload[i].vs1_valid = uop[i].vs1_valid;
        assign rs_payload[i].vs2_data  = operands[i].vs2;
        assign rs_payload[i].vs2_valid = uop[i].vs2_valid;
        assign rs_payload[i].vd_data   = operands[i].vd;
        assign rs_payload[i].vd_valid  = uop[i].vs3_valid;
        assign rs_payload[i].rs1_data  = uop[i].rs1_data;
        assign rs_payload[i].rs1_valid = uop[i].rs1_valid;

        assign rob_push[i].w_index  = uop[i].vd_index;
        assign rob_push[i].last_uop = uop[i].last_uop;
    end

    // Both stations see the same payload, the valids pick the target
    assign rs_alu = rs_payload;
    assign rs_mul = rs_payload;

    dispatch_ctrl dispatch_ctrl_inst (
        .uop_valid      (uop_valid),
        .rob_hazard     (rob_hazard),
        .uop_hazard     (uop_hazard),
        .struct_hazard  (struct_hazard),
        .exe_unit       (exe_unit),
        .rs_ready_alu   (rs_ready_alu),
        .rs_ready_mul   (rs_ready_mul),
        .rob_push_ready (rob_push_ready),
        .uop_ready      (uop_ready),
        .rs_valid_alu   (rs_valid_alu),
        .rs_valid_mul   (rs_valid_mul),
        .rob_push_valid (rob_push_valid)
    );

endmodule

// ==== tb/tb_vector_dispatch.sv ====
// Testbench for the vector dispatch stage
// Random LFSR stimulus in six biased phases, checked against a reference model

`include "dispatch_defines.svh"

module tb_vector_dispatch;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD = 50;
    localparam int DRIVE_DELAY = 1;
    localparam int CHECK_DELAY = 90;
    localparam int NUM_PHASES = 6;
    localparam int PHASE_CYCLES = 300;
    localparam int TIMEOUT_CYCLES = 2000;

    // ROB valid, w_valid, ready and source odds out of 8, then index bits, per phase
    localparam int BIAS [NUM_PHASES][5] = '{
        '{0, 8, 8, 3, 3},
        '{6, 8, 8, 4, 3},
        '{6, 4, 8, 4, 3},
        '{2, 6, 8, 4, 1},
        '{2, 8, 8, 7, 3},
        '{3, 6, 5, 4, 3}
    };

    typedef logic [`VLEN-1:0] value_t;

    logic clk;
    logic rst_n;
    logic [31:0] lfsr = 32'hc68f_86ed;
    int cycle_count = 0;
    int rob_valid_k;
    int w_valid_k;
    int ready_k;
    int src_k;
    int idx_bits;
    int dual_seen;
    int bypass_seen;
    int stall_seen;
    int pair_seen;
    int port_seen;
    int backpressure_seen;

    logic [`NUM_DP_UOP-1:0] uop_valid;
    logic [`NUM_DP_UOP-1:0] uop_ready;
    logic [`NUM_DP_UOP-1:0] rs_valid_alu;
    logic [`NUM_DP_UOP-1:0] rs_ready_alu;
    logic [`NUM_DP_UOP-1:0] rs_valid_mul;
    logic [`NUM_DP_UOP-1:0] rs_ready_mul;
    logic [`NUM_DP_UOP-1:0] rob_push_valid;
    logic [`NUM_DP_UOP-1:0] rob_push_ready;
    dispatch_pkg::uop_t [`NUM_DP_UOP-1:0] uop;
    dispatch_pkg::rs_uop_t [`NUM_DP_UOP-1:0] rs_alu;
    dispatch_pkg::rs_uop_t [`NUM_DP_UOP-1:0] rs_mul;
    dispatch_pkg::rob_uop_t [`NUM_DP_UOP-1:0] rob_push;
    dispatch_pkg::rob_index_t rob_tail;
    dispatch_pkg::vreg_index_t [`NUM_DP_VRF-1:0] vrf_rd_index;
    dispatch_pkg::vreg_data_t [`NUM_DP_VRF-1:0] vrf_rd_data;
    dispatch_pkg::vreg_data_t v0_mask;
    dispatch_pkg::rob_entry_t [`ROB_DEPTH-1:0] rob_entries;

    vector_dispatch vector_dispatch_inst (
        .uop_valid(uop_valid), .uop(uop), .uop_ready(uop_ready),
        .rs_valid_alu(rs_valid_alu), .rs_alu(rs_alu), .rs_ready_alu(rs_ready_alu),
        .rs_valid_mul(rs_valid_mul), .rs_mul(rs_mul), .rs_ready_mul(rs_ready_mul),
        .rob_push_valid(rob_push_valid), .rob_push(rob_push),
        .rob_push_ready(rob_push_ready), .rob_tail(rob_tail),
        .vrf_rd_index(vrf_rd_index), .vrf_rd_data(vrf_rd_data), .v0_mask(v0_mask),
        .rob_entries(rob_entries)
    );

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return value;
    endfunction

    // True with probability k out of 8
    function automatic logic chance(input int k);
        return rand_bits(3) < k;
    endfunction

    function automatic value_t random_vector();
        value_t value;
        for (int w = 0; w < `VLEN / 32; w++) begin
            value[w*32 +: 32] = rand_bits(32);
        end
        return value;
    endfunction

    task automatic report_mismatch(input string name, input value_t got, input value_t exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input value_t got, input value_t exp);
        assert (got === exp) else report_mismatch(name, got, exp);
    endtask

    task automatic set_bias(input int phase);
        rob_valid_k = BIAS[phase][0];
        w_valid_k = BIAS[phase][1];
        ready_k = BIAS[phase][2];
        src_k = BIAS[phase][3];
        idx_bits = BIAS[phase][4];
    endtask

    task automatic drive_random();
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            uop_valid[i] = chance(7);
            uop[i] = '0;
            uop[i].vs1_index = 5'(rand_bits(idx_bits));
            uop[i].vs1_valid = chance(src_k);
            uop[i].vs2_index = 5'(rand_bits(idx_bits));
            uop[i].vs2_valid = chance(src_k);
            uop[i].vd_index = 5'(rand_bits(idx_bits));
            uop[i].vd_valid = chance(6);
            uop[i].vs3_valid = chance(src_k);
            uop[i].vm = chance(4);
            uop[i].exe_unit = chance(4) ? dispatch_pkg::MUL : dispatch_pkg::ALU;
            uop[i].funct6 = 6'(rand_bits(6));
            uop[i].funct3 = 3'(rand_bits(3));
            uop[i].rs1_data = rand_bits(32);
            uop[i].rs1_valid = chance(4);
            uop[i].last_uop = chance(4);
            rs_ready_alu[i] = chance(ready_k);
            rs_ready_mul[i] = chance(ready_k);
            rob_push_ready[i] = chance(ready_k);
        end
        for (int k = 0; k < `ROB_DEPTH; k++) begin
            rob_entries[k].valid = chance(rob_valid_k);
            rob_entries[k].w_index = 5'(rand_bits(idx_bits));
            rob_entries[k].w_valid = chance(w_valid_k);
            rob_entries[k].w_data = random_vector();
        end
        for (int p = 0; p < `NUM_DP_VRF; p++) begin
            vrf_rd_data[p] = random_vector();
        end
        v0_mask = random_vector();
        rob_tail = 3'(rand_bits(3));
    endtask

    // Nearest ROB writer of a register going back from rob_tail
    task automatic find_writer(input dispatch_pkg::vreg_index_t idx, output logic hit,
                               output logic ready, output value_t data);
        dispatch_pkg::rob_index_t slot;
        hit = 1'b0;
        ready = 1'b0;
        data = '0;
        for (int d = 0; d < `ROB_DEPTH; d++) begin
            slot = rob_tail - 3'(d + 1);
            if (!hit && rob_entries[slot].valid && rob_entries[slot].w_index == idx) begin
                hit = 1'b1;
                ready = rob_entries[slot].w_valid;
                data = rob_entries[slot].w_data;
            end
        end
    endtask

    task automatic check_outputs();
        dispatch_pkg::vreg_index_t src_index [6];
        logic src_valid [6];
        int src_port [6];
        int n_src;
        dispatch_pkg::vreg_index_t exp_index [`NUM_DP_VRF];
        logic [`NUM_DP_UOP-1:0] rob_stall;
        logic [`NUM_DP_UOP-1:0] can_go;
        logic [`NUM_DP_UOP-1:0] exp_issue;
        logic [`NUM_DP_UOP-1:0] to_alu;
        logic pair_hazard;
        logic hit;
        logic ready;
        value_t rob_data;
        value_t exp_data;
        value_t got_data;
        string field;
        dispatch_pkg::rs_uop_t payload;
        // Sources in port order vs2, vs1, vd for uop0 then uop1
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            src_index[3*i] = uop[i].vs2_index;
            src_valid[3*i] = uop[i].vs2_valid;
            src_index[3*i+1] = uop[i].vs1_index;
            src_valid[3*i+1] = uop[i].vs1_valid;
            src_index[3*i+2] = uop[i].vd_index;
            src_valid[3*i+2] = uop[i].vs3_valid;
        end
        n_src = 0;
        rob_stall = '0;
        pair_hazard = 1'b0;
        for (int p = 0; p < `NUM_DP_VRF; p++) exp_index[p] = '0;
        for (int s = 0; s < 6; s++) begin
            src_port[s] = -1;
            if (src_valid[s]) begin
                if (n_src < `NUM_DP_VRF) begin
                    exp_index[n_src] = src_index[s];
                    src_port[s] = n_src;
                end
                n_src++;
                find_writer(src_index[s], hit, ready, rob_data);
                if (hit && !ready) rob_stall[s/3] = 1'b1;
                if (s >= 3 && uop_valid[0] && uop[0].vd_valid && src_index[s] == uop[0].vd_index)
                    pair_hazard = 1'b1;
            end
        end
        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            to_alu[i] = uop[i].exe_unit == dispatch_pkg::ALU;
            can_go[i] = uop_valid[i] && !rob_stall[i] && rob_push_ready[i] &&
                        (to_alu[i] ? rs_ready_alu[i] : rs_ready_mul[i]);
        end
        exp_issue[0] = can_go[0];
        exp_issue[1] = can_go[1] && can_go[0] && !pair_hazard && n_src <= `NUM_DP_VRF;

        for (int p = 0; p < `NUM_DP_VRF; p++)
            check_value($sformatf("vrf_rd_index[%0d]", p), value_t'(vrf_rd_index[p]),
                        value_t'(exp_index[p]));
        check_value("uop_ready", value_t'(uop_ready), value_t'(exp_issue));
        check_value("rob_push_valid", value_t'(rob_push_valid), value_t'(exp_issue));
        check_value("rs_valid_alu", value_t'(rs_valid_alu), value_t'(exp_issue & to_alu));
        check_value("rs_valid_mul", value_t'(rs_valid_mul), value_t'(exp_issue & ~to_alu));

        for (int i = 0; i < `NUM_DP_UOP; i++) begin
            if (exp_issue[i]) begin
                payload = to_alu[i] ? rs_alu[i] : rs_mul[i];
                check_value("rs.rob_entry", value_t'(payload.rob_entry),
                            value_t'(3'(rob_tail + 3'(i))));
                check_value("rs.rs1_data", value_t'(payload.rs1_data), value_t'(uop[i].rs1_data));
                check_value("rs.rs1_valid", value_t'(payload.rs1_valid),
                            value_t'(uop[i].rs1_valid));
                check_value("rs.funct6", value_t'(payload.funct6), value_t'(uop[i].funct6));
                check_value("rs.funct3", value_t'(payload.funct3), value_t'(uop[i].funct3));
                check_value("rs.vm", value_t'(payload.vm), value_t'(uop[i].vm));
                check_value("rs.vs1_valid", value_t'(payload.vs1_valid),
                            value_t'(uop[i].vs1_valid));
                check_value("rs.vs2_valid", value_t'(payload.vs2_valid),
                            value_t'(uop[i].vs2_valid));
                check_value("rs.vd_valid", value_t'(payload.vd_valid),
                            value_t'(uop[i].vs3_valid));
                check_value("rs.v0_data", payload.v0_data, v0_mask);
                check_value("rob_push.w_index", value_t'(rob_push[i].w_index),
                            value_t'(uop[i].vd_index));
                check_value("rob_push.last_uop", value_t'(rob_push[i].last_uop),
                            value_t'(uop[i].last_uop));
                for (int k = 0; k < 3; k++) begin
                    if (src_valid[3*i+k]) begin
                        find_writer(src_index[3*i+k], hit, ready, rob_data);
                        exp_data = hit ? rob_data : vrf_rd_data[src_port[3*i+k]];
                        got_data = (k == 0) ? payload.vs2_data :
                                   (k == 1) ? payload.vs1_data : payload.vd_data;
                        field = (k == 0) ? "vs2_data" : (k == 1) ? "vs1_data" : "vd_data";
                        check_value($sformatf("rs[%0d].%s", i, field), got_data, exp_data);
                        if (hit) bypass_seen++;
                    end
                end
            end
        end
        if (exp_issue == 2'b11) dual_seen++;
        if (uop_valid[0] && rob_stall[0]) stall_seen++;
        if (exp_issue[0] && can_go[1] && pair_hazard) pair_seen++;
        if (exp_issue[0] && can_go[1] && n_src > `NUM_DP_VRF) port_seen++;
        if (uop_valid[0] && !rob_stall[0] && !can_go[0]) backpressure_seen++;
    endtask

    initial begin
        uop_valid = '0;
        uop = '0;
        rs_ready_alu = '0;
        rs_ready_mul = '0;
        rob_push_ready = '0;
        rob_tail = '0;
        vrf_rd_data = '0;
        v0_mask = '0;
        rob_entries = '0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        for (int phase = 0; phase < NUM_PHASES; phase++) begin
            set_bias(phase);
            repeat (PHASE_CYCLES) begin
                @(posedge clk);
                #DRIVE_DELAY drive_random();
                #CHECK_DELAY check_outputs();
            end
        end
        if (dual_seen == 0 || bypass_seen == 0 || stall_seen == 0 || pair_seen == 0 ||
            port_seen == 0 || backpressure_seen == 0) begin
            $display("stimulus never reached one of the hazard or issue cases");
            $display("Test failed");
            $fatal(1);
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+design
design/dispatch_pkg.sv
design/dispatch_rob_hazard.sv
design/dispatch_uop_hazard.sv
design/dispatch_vrf_read.sv
design/dispatch_operand_select.sv
design/dispatch_ctrl.sv
design/vector_dispatch.sv
tb/tb_vector_dispatch.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_vector_dispatch
FILELIST = all.f
OBJ_DIR  = obj_dir
PASS_MSG = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
